/* rtl/lm_pkg.sv */
// Shared geometry, field widths and function codes for the local memory request path.
package lm_pkg;

    // *************************************************************************
    // memory geometry
    // *************************************************************************

    localparam int lm_banks      = 4;              // banks are word interleaved.
    localparam int lm_bank_sel_w = 2;
    localparam int lm_aw         = 12;             // byte address width.
    localparam int lm_idx_w      = 8;
    localparam int lm_depth      = 1 << lm_idx_w;  // words per bank.
    localparam int lm_off_w      = 2;              // byte offset inside a word.

    // *************************************************************************
    // field widths
    // *************************************************************************

    localparam int lm_dw     = 32;
    localparam int lm_be_w   = lm_dw / 8;
    localparam int lm_uw     = 3;
    localparam int lm_func_w = 3;

    // the bank number sits right above the byte offset, the word index above that.
    localparam int lm_bank_lsb = lm_off_w;
    localparam int lm_idx_lsb  = lm_bank_lsb + lm_bank_sel_w;

    // A-channel function codes.
    // codes not listed here are illegal and get squashed by the decoder.
    typedef enum logic [lm_func_w-1:0] {
        lm_func_read    = 3'd0,
        lm_func_write_b = 3'd1,
        lm_func_write_h = 3'd2,
        lm_func_write_w = 3'd3
    } lm_func_e;

endpackage

/* rtl/lm_a_req_decode.sv */
// Request producer: splits the byte address, builds byte enables and squashes misaligned requests.
`timescale 1ns/1ps

module lm_a_req_decode import lm_pkg::*; (
    input  logic                     a_valid,
    input  logic                     a_stall,
    input  logic [lm_aw-1:0]         a_addr,
    input  lm_func_e                 a_func,
    input  logic [lm_uw-1:0]         a_user,
    input  logic [lm_dw-1:0]         a_wdata,
    output logic                     a_ready,
    output logic                     us_valid,
    output logic                     us_stall,
    input  logic                     us_ready,
    output logic [lm_bank_sel_w-1:0] us_bank_sel,
    output logic [lm_idx_w-1:0]      us_idx,
    output lm_func_e                 us_func,
    output logic [lm_be_w-1:0]       us_be,
    output logic [lm_uw-1:0]         us_user,
    output logic [lm_dw-1:0]         us_wdata,
    output logic                     err_valid,
    output logic [lm_uw-1:0]         err_user
);

    logic [lm_off_w-1:0] off;
    logic                misaligned;

    assign off         = a_addr[lm_off_w-1:0];
    assign us_bank_sel = a_addr[lm_idx_lsb-1:lm_bank_lsb];
    assign us_idx      = a_addr[lm_idx_lsb +: lm_idx_w];

    // byte enables follow the function code, and narrow write data is copied to every lane.
    always_comb begin
        misaligned = 1'b0;
        us_be      = '0;
        us_wdata   = a_wdata;
        case (a_func)
            lm_func_read: begin
                us_be = '1;
            end
            lm_func_write_b: begin
                us_be    = lm_be_w'(1) << off;
                us_wdata = {lm_be_w{a_wdata[7:0]}};
            end
            lm_func_write_h: begin
                us_be      = lm_be_w'(2'b11) << {off[1], 1'b0};
                us_wdata   = {(lm_be_w / 2){a_wdata[15:0]}};
                misaligned = off[0];                  // odd halfword offset.
            end
            lm_func_write_w: begin
                us_be      = '1;
                misaligned = (off != '0);
            end
            default: begin
                misaligned = 1'b1;                    // illegal code.
            end
        endcase
    end

    assign us_valid = a_valid;
    assign us_stall = a_stall | misaligned;   // a squashed request still gets taken.
    assign us_func  = a_func;
    assign us_user  = a_user;
    assign a_ready  = us_ready;

    // the error pulses only in the cycle the request is accepted.
    assign err_valid = a_valid & us_ready & ~a_stall & misaligned;
    assign err_user  = a_user;

endmodule

/* rtl/lm_a_bank_sel.sv */
// Request buffer that routes decoded requests to their bank and holds one refused request.
`timescale 1ns/1ps

module lm_a_bank_sel import lm_pkg::*; (
    input  logic                                  core_clk,
    input  logic                                  core_reset_n,
    input  logic                                  us_valid,
    input  logic                                  us_stall,
    output logic                                  us_ready,
    input  logic [lm_bank_sel_w-1:0]              us_bank_sel,
    input  logic [lm_idx_w-1:0]                   us_idx,
    input  lm_func_e                              us_func,
    input  logic [lm_be_w-1:0]                    us_be,
    input  logic [lm_uw-1:0]                      us_user,
    input  logic [lm_dw-1:0]                      us_wdata,
    output logic [lm_banks-1:0]                   ds_valid,
    output logic [lm_banks-1:0]                   ds_stall,
    input  logic [lm_banks-1:0]                   ds_ready,
    output logic [lm_banks-1:0][lm_idx_w-1:0]     ds_idx,
    output lm_func_e [lm_banks-1:0]               ds_func,
    output logic [lm_banks-1:0][lm_be_w-1:0]      ds_be,
    output logic [lm_banks-1:0][lm_uw-1:0]        ds_user,
    output logic [lm_banks-1:0][lm_dw-1:0]        ds_wdata
);

    // *************************************************************************
    // hold control
    // *************************************************************************

    logic                     hold_q;
    logic                     hold_d;
    logic                     capture;
    logic                     release_hold;
    logic [lm_bank_sel_w-1:0] hold_bank_q;
    logic [lm_idx_w-1:0]      hold_idx_q;
    lm_func_e                 hold_func_q;
    logic [lm_be_w-1:0]       hold_be_q;
    logic [lm_uw-1:0]         hold_user_q;
    logic [lm_dw-1:0]         hold_wdata_q;

    // a live request that its bank refuses is taken into the holding register.
    assign capture = ~hold_q & us_valid & ~us_stall & ~ds_ready[us_bank_sel];

    // the hold ends at the edge where the held bank finally accepts.
    assign release_hold = hold_q & ds_ready[hold_bank_q];

    assign hold_d = (hold_q | capture) & ~release_hold;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= hold_d;
        end
    end

    // payload of the refused request.
    always_ff @(posedge core_clk) begin
        if (capture) begin
            hold_bank_q  <= us_bank_sel;
            hold_idx_q   <= us_idx;
            hold_func_q  <= us_func;
            hold_be_q    <= us_be;
            hold_user_q  <= us_user;
            hold_wdata_q <= us_wdata;
        end
    end

    assign us_ready = ~hold_q;   // upstream waits while a request is parked.

    // *************************************************************************
    // per-bank routing
    // *************************************************************************

    // while idle every bank sees the request, but all except the addressed one are
    // stalled. While holding, only the held bank sees a valid request.
    always_comb begin
        for (int b = 0; b < lm_banks; b++) begin
            if (hold_q) begin
                ds_valid[b] = (hold_bank_q == lm_bank_sel_w'(b));
                ds_stall[b] = 1'b0;
                ds_idx[b]   = hold_idx_q;
                ds_func[b]  = hold_func_q;
                ds_be[b]    = hold_be_q;
                ds_user[b]  = hold_user_q;
                ds_wdata[b] = hold_wdata_q;
            end else begin
                ds_valid[b] = us_valid;
                ds_stall[b] = (us_bank_sel != lm_bank_sel_w'(b)) | us_stall;
                ds_idx[b]   = us_idx;
                ds_func[b]  = us_func;
                ds_be[b]    = us_be;
                ds_user[b]  = us_user;
                ds_wdata[b] = us_wdata;
            end
        end
    end

endmodule

/* rtl/lm_bank.sv */
// One storage bank: byte-enabled writes with one cycle of write recovery and registered reads.
`timescale 1ns/1ps

module lm_bank import lm_pkg::*; (
    input  logic                core_clk,
    input  logic                core_reset_n,
    input  logic                req_valid,
    input  logic                req_stall,
    output logic                req_ready,
    input  logic [lm_idx_w-1:0] req_idx,
    input  lm_func_e            req_func,
    input  logic [lm_be_w-1:0]  req_be,
    input  logic [lm_uw-1:0]    req_user,
    input  logic [lm_dw-1:0]    req_wdata,
    output logic                rsp_valid,
    output logic [lm_dw-1:0]    rsp_data,
    output logic [lm_uw-1:0]    rsp_user
);

    logic [lm_dw-1:0] mem [lm_depth];
    logic             perform;
    logic             wr_fire;
    logic             rd_fire;
    logic             recov_q;

    // a stalled request is accepted but leaves no trace.
    assign perform = req_valid & req_ready & ~req_stall;
    assign rd_fire = perform & (req_func == lm_func_read);
    assign wr_fire = perform & (req_func != lm_func_read);

    // *************************************************************************
    // write recovery
    // *************************************************************************

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            recov_q <= 1'b0;
        end else begin
            recov_q <= wr_fire;   // busy for the one cycle after a write.
        end
    end

    assign req_ready = ~recov_q;

    // *************************************************************************
    // storage and read response
    // *************************************************************************

    always_ff @(posedge core_clk) begin
        if (wr_fire) begin
            for (int i = 0; i < lm_be_w; i++) begin
                if (req_be[i]) begin
                    mem[req_idx][8*i +: 8] <= req_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_fire;
        end
    end

    // read data and tag come out one cycle after the read is performed.
    always_ff @(posedge core_clk) begin
        if (rd_fire) begin
            rsp_data <= mem[req_idx];
            rsp_user <= req_user;
        end
    end

endmodule

/* rtl/lm_bank_array.sv */
// Request consumer: four storage banks and the merge of their read responses into one D channel.
`timescale 1ns/1ps

module lm_bank_array import lm_pkg::*; (
    input  logic                              core_clk,
    input  logic                              core_reset_n,
    input  logic [lm_banks-1:0]               ds_valid,
    input  logic [lm_banks-1:0]               ds_stall,
    output logic [lm_banks-1:0]               ds_ready,
    input  logic [lm_banks-1:0][lm_idx_w-1:0] ds_idx,
    input  lm_func_e [lm_banks-1:0]           ds_func,
    input  logic [lm_banks-1:0][lm_be_w-1:0]  ds_be,
    input  logic [lm_banks-1:0][lm_uw-1:0]    ds_user,
    input  logic [lm_banks-1:0][lm_dw-1:0]    ds_wdata,
    output logic                              d_valid,
    output logic [lm_dw-1:0]                  d_data,
    output logic [lm_uw-1:0]                  d_user
);

    logic [lm_banks-1:0]            rsp_valid;
    logic [lm_banks-1:0][lm_dw-1:0] rsp_data;
    logic [lm_banks-1:0][lm_uw-1:0] rsp_user;

    for (genvar g = 0; g < lm_banks; g++) begin : gen_bank
        lm_bank u_bank (
            .core_clk     (core_clk),
            .core_reset_n (core_reset_n),
            .req_valid    (ds_valid[g]),
            .req_stall    (ds_stall[g]),
            .req_ready    (ds_ready[g]),
            .req_idx      (ds_idx[g]),
            .req_func     (ds_func[g]),
            .req_be       (ds_be[g]),
            .req_user     (ds_user[g]),
            .req_wdata    (ds_wdata[g]),
            .rsp_valid    (rsp_valid[g]),
            .rsp_data     (rsp_data[g]),
            .rsp_user     (rsp_user[g])
        );
    end

    // *************************************************************************
    // response merge
    // *************************************************************************

    // only one request reaches a bank per cycle, so at most one bank answers.
    always_comb begin
        d_valid = |rsp_valid;
        d_data  = '0;
        d_user  = '0;
        for (int b = 0; b < lm_banks; b++) begin
            if (rsp_valid[b]) begin
                d_data = rsp_data[b];
                d_user = rsp_user[b];
            end
        end
    end

endmodule

/* rtl/lm_a_subsys.sv */
// Top level of the local memory request side: decoder, bank selector and bank array.
`timescale 1ns/1ps

module lm_a_subsys import lm_pkg::*; (
    input  logic              core_clk,
    input  logic              core_reset_n,
    input  logic              a_valid,
    input  logic              a_stall,
    output logic              a_ready,
    input  logic [lm_aw-1:0]  a_addr,
    input  lm_func_e          a_func,
    input  logic [lm_uw-1:0]  a_user,
    input  logic [lm_dw-1:0]  a_wdata,
    output logic              err_valid,
    output logic [lm_uw-1:0]  err_user,
    output logic              d_valid,
    output logic [lm_dw-1:0]  d_data,
    output logic [lm_uw-1:0]  d_user
);

    // decoder to selector.
    logic                     us_valid;
    logic                     us_stall;
    logic                     us_ready;
    logic [lm_bank_sel_w-1:0] us_bank_sel;
    logic [lm_idx_w-1:0]      us_idx;
    lm_func_e                 us_func;
    logic [lm_be_w-1:0]       us_be;
    logic [lm_uw-1:0]         us_user;
    logic [lm_dw-1:0]         us_wdata;

    // selector to banks, one slot per bank.
    logic [lm_banks-1:0]               ds_valid;
    logic [lm_banks-1:0]               ds_stall;
    logic [lm_banks-1:0]               ds_ready;
    logic [lm_banks-1:0][lm_idx_w-1:0] ds_idx;
    lm_func_e [lm_banks-1:0]           ds_func;
    logic [lm_banks-1:0][lm_be_w-1:0]  ds_be;
    logic [lm_banks-1:0][lm_uw-1:0]    ds_user;
    logic [lm_banks-1:0][lm_dw-1:0]    ds_wdata;

    lm_a_req_decode u_decode (
        .a_valid     (a_valid),
        .a_stall     (a_stall),
        .a_addr      (a_addr),
        .a_func      (a_func),
        .a_user      (a_user),
        .a_wdata     (a_wdata),
        .a_ready     (a_ready),
        .us_valid    (us_valid),
        .us_stall    (us_stall),
        .us_ready    (us_ready),
        .us_bank_sel (us_bank_sel),
        .us_idx      (us_idx),
        .us_func     (us_func),
        .us_be       (us_be),
        .us_user     (us_user),
        .us_wdata    (us_wdata),
        .err_valid   (err_valid),
        .err_user    (err_user)
    );

    lm_a_bank_sel u_bank_sel (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .us_valid     (us_valid),
        .us_stall     (us_stall),
        .us_ready     (us_ready),
        .us_bank_sel  (us_bank_sel),
        .us_idx       (us_idx),
        .us_func      (us_func),
        .us_be        (us_be),
        .us_user      (us_user),
        .us_wdata     (us_wdata),
        .ds_valid     (ds_valid),
        .ds_stall     (ds_stall),
        .ds_ready     (ds_ready),
        .ds_idx       (ds_idx),
        .ds_func      (ds_func),
        .ds_be        (ds_be),
        .ds_user      (ds_user),
        .ds_wdata     (ds_wdata)
    );

    lm_bank_array u_bank_array (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .ds_valid     (ds_valid),
        .ds_stall     (ds_stall),
        .ds_ready     (ds_ready),
        .ds_idx       (ds_idx),
        .ds_func      (ds_func),
        .ds_be        (ds_be),
        .ds_user      (ds_user),
        .ds_wdata     (ds_wdata),
        .d_valid      (d_valid),
        .d_data       (d_data),
        .d_user       (d_user)
    );

endmodule

/* test/tb_clk_gen.sv */
// Testbench clock and reset source: 10 ns clock, reset held low for the first 8 cycles.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic core_clk,
    output logic core_reset_n
);

    localparam int half_period  = 5;
    localparam int reset_cycles = 8;

    initial begin
        core_clk = 1'b0;
        forever #(half_period) core_clk = ~core_clk;
    end

    initial begin
        core_reset_n = 1'b0;
        repeat (reset_cycles) @(posedge core_clk);
        #1 core_reset_n = 1'b1;   // released just after the edge, like the other inputs.
    end

endmodule

/* test/tb_lm_a_subsys.sv */
// Directed testbench for the local memory request side, run as the simulation top.
`timescale 1ns/1ps

module tb_lm_a_subsys import lm_pkg::*; ();

    localparam int wait_limit = 40;   // cycles allowed for any single wait.

    logic             core_clk;
    logic             core_reset_n;
    logic             a_valid;
    logic             a_stall;
    logic             a_ready;
    logic [lm_aw-1:0] a_addr;
    lm_func_e         a_func;
    logic [lm_uw-1:0] a_user;
    logic [lm_dw-1:0] a_wdata;
    logic             err_valid;
    logic [lm_uw-1:0] err_user;
    logic             d_valid;
    logic [lm_dw-1:0] d_data;
    logic [lm_uw-1:0] d_user;

    int               check_count = 0;
    int               error_count = 0;
    logic [31:0]      lcg_state   = 32'd31;
    logic [lm_dw-1:0] model_mem [1 << (lm_aw - lm_off_w)];   // one entry per word address.
    logic [lm_dw-1:0] exp_data_q [$];
    logic [lm_uw-1:0] exp_user_q [$];
    string            exp_name_q [$];

    tb_clk_gen u_clk_gen (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n)
    );

    lm_a_subsys DUT (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .a_valid      (a_valid),
        .a_stall      (a_stall),
        .a_ready      (a_ready),
        .a_addr       (a_addr),
        .a_func       (a_func),
        .a_user       (a_user),
        .a_wdata      (a_wdata),
        .err_valid    (err_valid),
        .err_user     (err_user),
        .d_valid      (d_valid),
        .d_data       (d_data),
        .d_user       (d_user)
    );

    // *************************************************************************
    // compare tasks, random source and reference model
    // *************************************************************************

    task automatic check_data(input string name, input logic [lm_dw-1:0] exp,
                              input logic [lm_dw-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_user(input string name, input logic [lm_uw-1:0] exp,
                              input logic [lm_uw-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected tag %0d, actual tag %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // narrow writes land on the lanes picked by the byte offset.
    task automatic model_write(input logic [lm_aw-1:0] addr, input lm_func_e func,
                               input logic [lm_dw-1:0] wdata);
        logic [lm_aw-lm_off_w-1:0] waddr;
        int                        off;
        waddr = addr[lm_aw-1:lm_off_w];
        off   = addr[lm_off_w-1:0];
        case (func)
            lm_func_write_b: model_mem[waddr][8*off +: 8]  = wdata[7:0];
            lm_func_write_h: model_mem[waddr][8*off +: 16] = wdata[15:0];
            default:         model_mem[waddr]              = wdata;
        endcase
    endtask

    // called just after a rising edge, returns just after the edge that took the request.
    task automatic send_req(input string name, input logic [lm_aw-1:0] addr,
                            input lm_func_e func, input logic [lm_uw-1:0] user,
                            input logic [lm_dw-1:0] wdata, input logic stall,
                            input logic exp_err, output int waited);
        logic accepted;
        a_valid = 1'b1;
        a_stall = stall;
        a_addr  = addr;
        a_func  = func;
        a_user  = user;
        a_wdata = wdata;
        waited  = 0;
        @(negedge core_clk);
        while (!a_ready && waited < wait_limit) begin
            @(negedge core_clk);
            waited++;
        end
        accepted = a_ready;
        if (!accepted) begin
            error_count++;
            $display("%s: request was not accepted within %0d cycles", name, wait_limit);
        end else begin
            check_flag({name, " err_valid"}, exp_err, err_valid);
            if (exp_err) begin
                check_user({name, " err_user"}, user, err_user);
            end
        end
        @(posedge core_clk);
        #1;
        a_valid = 1'b0;
        a_stall = 1'b0;
        if (accepted && !stall && !exp_err) begin
            if (func == lm_func_read) begin
                exp_data_q.push_back(model_mem[addr[lm_aw-1:lm_off_w]]);
                exp_user_q.push_back(user);
                exp_name_q.push_back(name);
            end else begin
                model_write(addr, func, wdata);
            end
        end
    endtask

    task automatic drain_responses(input string name);
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < wait_limit) begin
            @(posedge core_clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            error_count++;
            $display("%s: %0d read responses never arrived", name, exp_data_q.size());
            exp_data_q.delete();
            exp_user_q.delete();
            exp_name_q.delete();
        end
        repeat (2) @(posedge core_clk);   // room for a stray response to show up.
        #1;
    endtask

    // responses are matched against the reads in the order they were issued.
    always @(negedge core_clk) begin
        if (core_reset_n && d_valid) begin
            if (exp_data_q.size() == 0) begin
                error_count++;
                $display("read response with tag %0d arrived with no read outstanding", d_user);
            end else begin
                check_data({exp_name_q[0], " d_data"}, exp_data_q[0], d_data);
                check_user({exp_name_q[0], " d_user"}, exp_user_q[0], d_user);
                exp_data_q.delete(0);
                exp_user_q.delete(0);
                exp_name_q.delete(0);
            end
        end
    end

    // *************************************************************************
    // directed tests
    // *************************************************************************

    task automatic test_reset_state();
        @(negedge core_clk);
        check_flag("reset a_ready", 1'b1, a_ready);
        check_flag("reset d_valid", 1'b0, d_valid);
        check_flag("reset err_valid", 1'b0, err_valid);
        @(posedge core_clk);
        #1;
    endtask

    task automatic test_word_rw();
        int waited;
        for (int i = 0; i < lm_banks; i++) begin
            send_req("word write", 12'h100 + 12'(4 * i), lm_func_write_w, lm_uw'(i),
                     next_rand(), 1'b0, 1'b0, waited);
        end
        for (int i = 0; i < lm_banks; i++) begin
            send_req("word read", 12'h100 + 12'(4 * i), lm_func_read, lm_uw'(i + 4),
                     '0, 1'b0, 1'b0, waited);
        end
        drain_responses("word read");
    endtask

    task automatic test_partial_writes();
        int waited;
        send_req("partial", 12'h200, lm_func_write_w, 3'd1, 32'h1122_3344, 1'b0, 1'b0, waited);
        send_req("partial", 12'h201, lm_func_write_b, 3'd2, 32'h0000_00ab, 1'b0, 1'b0, waited);
        send_req("partial", 12'h202, lm_func_write_h, 3'd3, 32'h0000_cdef, 1'b0, 1'b0, waited);
        send_req("partial", 12'h214, lm_func_write_w, 3'd4, 32'h5566_7788, 1'b0, 1'b0, waited);
        send_req("partial", 12'h214, lm_func_write_h, 3'd5, 32'h0000_1234, 1'b0, 1'b0, waited);
        send_req("partial", 12'h217, lm_func_write_b, 3'd6, 32'h0000_009a, 1'b0, 1'b0, waited);
        send_req("partial read", 12'h200, lm_func_read, 3'd7, '0, 1'b0, 1'b0, waited);
        send_req("partial read", 12'h214, lm_func_read, 3'd0, '0, 1'b0, 1'b0, waited);
        drain_responses("partial read");
    endtask

    task automatic test_back_to_back();
        int   waited;
        logic saw_low;
        saw_low = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_req("same bank write", 12'h308 + 12'(16 * i), lm_func_write_w, lm_uw'(i),
                     next_rand(), 1'b0, 1'b0, waited);
            if (waited > 0) begin
                saw_low = 1'b1;
            end
        end
        check_flag("same bank a_ready dropped", 1'b1, saw_low);
        for (int i = 0; i < 3; i++) begin
            send_req("same bank read", 12'h308 + 12'(16 * i), lm_func_read, lm_uw'(i + 3),
                     '0, 1'b0, 1'b0, waited);
        end
        drain_responses("same bank read");
    endtask

    task automatic test_error_squash();
        int waited;
        send_req("odd halfword", 12'h101, lm_func_write_h, 3'd5, 32'hdead_beef, 1'b0, 1'b1, waited);
        send_req("offset word", 12'h102, lm_func_write_w, 3'd6, 32'hdead_beef, 1'b0, 1'b1, waited);
        send_req("illegal code", 12'h100, lm_func_e'(3'd7), 3'd7, 32'hdead_beef, 1'b0, 1'b1,
                 waited);
        send_req("stalled write", 12'h100, lm_func_write_w, 3'd2, 32'hdead_beef, 1'b1, 1'b0,
                 waited);
        drain_responses("squashed requests");
        send_req("squash read", 12'h100, lm_func_read, 3'd3, '0, 1'b0, 1'b0, waited);
        drain_responses("squash read");
    endtask

    task automatic test_random();
        logic [31:0]      r;
        logic [lm_aw-1:0] addr;
        lm_func_e         func;
        int               waited;
        // the window is filled first with a pattern made of the whole word address.
        for (int w = 0; w < 16; w++) begin
            addr = 12'h400 + 12'(4 * w);
            send_req("random fill", addr, lm_func_write_w, 3'd0,
                     {addr[11:2], 6'h2a, ~addr[11:2], 6'h15}, 1'b0, 1'b0, waited);
        end
        for (int n = 0; n < 200; n++) begin
            r    = next_rand();
            func = lm_func_e'({1'b0, r[27:26]});
            addr = 12'h400 + {6'd0, r[31:28], 2'b00};
            case (func)
                lm_func_write_b: addr[1:0] = r[25:24];
                lm_func_write_h: addr[1:0] = {r[25], 1'b0};
                default:         addr[1:0] = 2'b00;
            endcase
            send_req("random", addr, func, r[23:21], next_rand(), 1'b0, 1'b0, waited);
        end
        drain_responses("random");
    endtask

    initial begin : main_seq
        int waited;
        a_valid = 1'b0;
        a_stall = 1'b0;
        a_addr  = '0;
        a_func  = lm_func_read;
        a_user  = '0;
        a_wdata = '0;
        waited  = 0;
        while (core_reset_n !== 1'b1 && waited < wait_limit) begin
            @(posedge core_clk);
            waited++;
        end
        if (core_reset_n !== 1'b1) begin
            error_count++;
            $display("reset was never released");
        end
        #1;
        test_reset_state();
        test_word_rw();
        test_partial_writes();
        test_back_to_back();
        test_error_squash();
        test_random();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/lm_pkg.sv
rtl/lm_a_req_decode.sv
rtl/lm_a_bank_sel.sv
rtl/lm_bank.sv
rtl/lm_bank_array.sv
rtl/lm_a_subsys.sv
test/tb_clk_gen.sv
test/tb_lm_a_subsys.sv

/* Bender.yml */
package:
  name: lm_a_subsys

sources:
  - rtl/lm_pkg.sv
  - rtl/lm_a_req_decode.sv
  - rtl/lm_a_bank_sel.sv
  - rtl/lm_bank.sv
  - rtl/lm_bank_array.sv
  - rtl/lm_a_subsys.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_lm_a_subsys.sv
